/* Makefile */
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/100ps
SIM_FLAGS  = --binary --timing --timescale 1ns/100ps
TOP        = vdp_main_tb
RTL_TOP    = vdp_main
FILELIST   = vdp.f
SIM_BIN    = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(SIM_BIN) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf obj_dir

/* hdl/bus_regs.sv */
// cpu byte bus front end: register file, word assembly and vram port client
// drives the four-phase request port towards vram_arb
`default_nettype none
`timescale 1ns/100ps

module bus_regs(
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   bus_cs_n_i,     // strobe, active low
    input  wire logic                                   bus_rd_nwr_i,   // 1 = read
    input  wire logic [vdp_regs_pkg::REG_NUM_W-1:0]     bus_reg_num_i,
    input  wire logic                                   bus_bytesel_i,  // 0 = high byte
    input  wire logic [7:0]                             bus_data_i,
    output logic      [7:0]                             bus_data_o,
    output logic                                        regs_req_o,
    output logic                                        regs_wr_o,
    output logic      [vdp_video_pkg::VADDR_W-1:0]      regs_addr_o,
    output logic      [vdp_video_pkg::WORD_W-1:0]       regs_wdata_o,
    input  wire logic                                   regs_ack_i,
    input  wire logic [vdp_video_pkg::WORD_W-1:0]       regs_rdata_i,
    output logic      [vdp_regs_pkg::INTR_W-1:0]        intr_mask_o,
    output logic      [vdp_regs_pkg::INTR_W-1:0]        intr_clear_o,   // one cycle
    input  wire logic [vdp_regs_pkg::INTR_W-1:0]        intr_status_i,
    output logic      [vdp_video_pkg::VCNT_W-1:0]       line_cmp_o,
    output logic      [vdp_video_pkg::VADDR_W-1:0]      disp_base_o
);
    import vdp_video_pkg::*;
    import vdp_regs_pkg::*;

    enum logic [1:0] {ST_IDLE, ST_REQ, ST_ACK_LOW} state;

    logic [7:0]         hold_hi;        // high byte waits here for the low byte
    logic [WORD_W-1:0]  wr_word;
    logic               wr_hi;
    logic               wr_lo;
    logic               rd_any;
    logic [VADDR_W-1:0] vram_addr;
    logic [VADDR_W-1:0] vram_incr;
    logic [WORD_W-1:0]  prefetch;       // last vram read result
    logic               go;             // launch a vram access this cycle
    logic               go_wr;
    logic [VADDR_W-1:0] go_addr;
    logic [WORD_W-1:0]  rd_word;

    assign wr_hi   = !bus_cs_n_i && !bus_rd_nwr_i && !bus_bytesel_i;
    assign wr_lo   = !bus_cs_n_i && !bus_rd_nwr_i && bus_bytesel_i;  // commit
    assign rd_any  = !bus_cs_n_i && bus_rd_nwr_i;
    assign wr_word = {hold_hi, bus_data_i};

    // low byte write to INTR clears the status bits written as 1
    assign intr_clear_o = (wr_lo && bus_reg_num_i == REG_INTR) ? bus_data_i[INTR_W-1:0] : '0;

    // which bus cycles start a vram access, and where
    always_comb begin
        go      = 1'b0;
        go_wr   = 1'b0;
        go_addr = vram_addr;
        if (wr_lo && bus_reg_num_i == REG_VRAM_ADDR) begin
            go      = 1'b1;                     // prefetch at the new address
            go_addr = wr_word[VADDR_W-1:0];
        end
        if (bus_reg_num_i == REG_VRAM_DATA && bus_bytesel_i && !bus_cs_n_i) begin
            go    = 1'b1;                       // lo read refills, lo write stores
            go_wr = !bus_rd_nwr_i;
        end
        go = go && (state == ST_IDLE);          // dropped while busy, cpu polls first
    end

    // register read mux
    always_comb begin
        rd_word = '0;
        case (bus_reg_num_i)
            REG_VRAM_ADDR: rd_word[VADDR_W-1:0] = vram_addr;
            REG_VRAM_DATA: rd_word = prefetch;
            REG_VRAM_INCR: rd_word[VADDR_W-1:0] = vram_incr;
            REG_INTR: begin
                rd_word[8 +: INTR_W]  = intr_mask_o;
                rd_word[INTR_W-1:0]   = intr_status_i;
            end
            REG_LINE_CMP:  rd_word[VCNT_W-1:0] = line_cmp_o;
            REG_DISP_BASE: rd_word[VADDR_W-1:0] = disp_base_o;
            REG_STATUS:    rd_word[STATUS_BUSY] = (state != ST_IDLE);
            default:       rd_word = '0;   // unused registers read 0
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hold_hi     <= 8'h00;
            vram_addr   <= '0;
            vram_incr   <= VADDR_W'(1);
            line_cmp_o  <= '0;
            disp_base_o <= '0;
            intr_mask_o <= '0;
            prefetch    <= '0;
            bus_data_o  <= 8'h00;
            regs_req_o  <= 1'b0;
            regs_wr_o   <= 1'b0;
            state       <= ST_IDLE;
        end else begin
            if (wr_hi) begin
                hold_hi <= bus_data_i;
                if (bus_reg_num_i == REG_INTR) begin
                    intr_mask_o <= bus_data_i[INTR_W-1:0];   // mask takes effect at once
                end
            end
            if (wr_lo) begin
                case (bus_reg_num_i)
                    REG_VRAM_ADDR: vram_addr   <= wr_word[VADDR_W-1:0];
                    REG_VRAM_INCR: vram_incr   <= wr_word[VADDR_W-1:0];
                    REG_LINE_CMP:  line_cmp_o  <= wr_word[VCNT_W-1:0];
                    REG_DISP_BASE: disp_base_o <= wr_word[VADDR_W-1:0];
                    default: ;
                endcase
            end
            if (rd_any) begin
                bus_data_o <= bus_bytesel_i ? rd_word[7:0] : rd_word[WORD_W-1 -: 8];
            end

            // four-phase request fsm
            case (state)
                ST_IDLE: if (go) begin
                    regs_req_o <= 1'b1;
                    regs_wr_o  <= go_wr;
                    vram_addr  <= go_addr + vram_incr;  // every access advances
                    state      <= ST_REQ;
                end
                ST_REQ: if (regs_ack_i) begin
                    regs_req_o <= 1'b0;
                    if (!regs_wr_o) begin
                        prefetch <= regs_rdata_i;
                    end
                    state <= ST_ACK_LOW;
                end
                default: if (!regs_ack_i) begin
                    state <= ST_IDLE;                   // arb has released ack
                end
            endcase
        end
    end

    // request payload, held while req is high
    always_ff @(posedge clk) begin
        if (go) begin
            regs_addr_o  <= go_addr;
            regs_wdata_o <= wr_word;
        end
    end

endmodule

`default_nettype wire

/* hdl/intr_ctrl.sv */
// sticky interrupt status with mask, drives the cpu interrupt line
`default_nettype none
`timescale 1ns/100ps

module intr_ctrl(
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic [vdp_regs_pkg::INTR_W-1:0]    intr_signal_i,  // one-cycle events
    input  wire logic [vdp_regs_pkg::INTR_W-1:0]    intr_clear_i,
    input  wire logic [vdp_regs_pkg::INTR_W-1:0]    intr_mask_i,
    output logic      [vdp_regs_pkg::INTR_W-1:0]    intr_status_o,
    output logic                                    bus_intr_o      // level
);
    import vdp_regs_pkg::*;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            intr_status_o <= {INTR_W{1'b0}};
            bus_intr_o    <= 1'b0;
        end else begin
            // a new event beats a clear of the same bit
            intr_status_o <= (intr_status_o & ~intr_clear_i) | intr_signal_i;
            bus_intr_o    <= |(intr_status_o & intr_mask_i);
        end
    end

endmodule

`default_nettype wire

/* hdl/vdp_main.sv */
// video display controller top: cpu register bus, vram, scan-out and interrupts
// pixel_o is a 4-bit color index valid while dv_de_o is high
`default_nettype none
`timescale 1ns/100ps

module vdp_main(
    input  wire logic                                   clk,
    input  wire logic                                   reset_i,
    input  wire logic                                   bus_cs_n_i,
    input  wire logic                                   bus_rd_nwr_i,
    input  wire logic [vdp_regs_pkg::REG_NUM_W-1:0]     bus_reg_num_i,
    input  wire logic                                   bus_bytesel_i,
    input  wire logic [7:0]                             bus_data_i,
    output logic      [7:0]                             bus_data_o,
    output logic                                        bus_intr_o,
    output logic                                        hsync_o,
    output logic                                        vsync_o,
    output logic                                        dv_de_o,
    output logic      [vdp_video_pkg::PIX_W-1:0]        pixel_o
);
    import vdp_video_pkg::*;
    import vdp_regs_pkg::*;

    // cpu side of the vram port
    logic               regs_req;
    logic               regs_wr;
    logic [VADDR_W-1:0] regs_addr;
    logic [WORD_W-1:0]  regs_wdata;
    logic               regs_ack;
    logic [WORD_W-1:0]  regs_rdata;

    // scan-out side
    logic               vid_rd;
    logic [VADDR_W-1:0] vid_addr;
    logic [WORD_W-1:0]  vid_rdata;
    logic [VCNT_W-1:0]  line_cmp;
    logic [VADDR_W-1:0] disp_base;
    logic               frame_start;
    logic               line_match;

    logic [INTR_W-1:0]  intr_signal;
    logic [INTR_W-1:0]  intr_mask;
    logic [INTR_W-1:0]  intr_clear;
    logic [INTR_W-1:0]  intr_status;

    assign intr_signal[INTR_FRAME] = frame_start;
    assign intr_signal[INTR_LINE]  = line_match;

    bus_regs bus_regs(
        .clk(clk),                      .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n_i),        .bus_rd_nwr_i(bus_rd_nwr_i),
        .bus_reg_num_i(bus_reg_num_i),  .bus_bytesel_i(bus_bytesel_i),
        .bus_data_i(bus_data_i),        .bus_data_o(bus_data_o),
        .regs_req_o(regs_req),          .regs_wr_o(regs_wr),
        .regs_addr_o(regs_addr),        .regs_wdata_o(regs_wdata),
        .regs_ack_i(regs_ack),          .regs_rdata_i(regs_rdata),
        .intr_mask_o(intr_mask),        .intr_clear_o(intr_clear),
        .intr_status_i(intr_status),
        .line_cmp_o(line_cmp),          .disp_base_o(disp_base)
    );

    vram_arb vram_arb(
        .clk(clk),                      .reset_i(reset_i),
        .vid_rd_i(vid_rd),              .vid_addr_i(vid_addr),
        .vid_rdata_o(vid_rdata),
        .regs_req_i(regs_req),          .regs_wr_i(regs_wr),
        .regs_addr_i(regs_addr),        .regs_wdata_i(regs_wdata),
        .regs_ack_o(regs_ack),          .regs_rdata_o(regs_rdata)
    );

    video_timing video_timing(
        .clk(clk),                      .reset_i(reset_i),
        .disp_base_i(disp_base),        .line_cmp_i(line_cmp),
        .vid_rd_o(vid_rd),              .vid_addr_o(vid_addr),
        .vid_rdata_i(vid_rdata),
        .hsync_o(hsync_o),              .vsync_o(vsync_o),
        .dv_de_o(dv_de_o),              .pixel_o(pixel_o),
        .frame_start_o(frame_start),    .line_match_o(line_match)
    );

    intr_ctrl intr_ctrl(
        .clk(clk),                      .reset_i(reset_i),
        .intr_signal_i(intr_signal),    .intr_clear_i(intr_clear),
        .intr_mask_i(intr_mask),        .intr_status_o(intr_status),
        .bus_intr_o(bus_intr_o)
    );

endmodule

`default_nettype wire

/* hdl/vdp_regs_pkg.sv */
// cpu register map and interrupt bit layout
// shared by the bus decoder, the interrupt block and the top level
`default_nettype none

package vdp_regs_pkg;

    localparam int REG_NUM_W = 4;

    // register numbers on bus_reg_num_i
    localparam logic [REG_NUM_W-1:0] REG_VRAM_ADDR = 4'h0;  // auto-incrementing pointer
    localparam logic [REG_NUM_W-1:0] REG_VRAM_DATA = 4'h1;  // data port at pointer
    localparam logic [REG_NUM_W-1:0] REG_VRAM_INCR = 4'h2;
    localparam logic [REG_NUM_W-1:0] REG_INTR      = 4'h3;  // hi = mask, lo = status
    localparam logic [REG_NUM_W-1:0] REG_LINE_CMP  = 4'h4;
    localparam logic [REG_NUM_W-1:0] REG_DISP_BASE = 4'h5;
    localparam logic [REG_NUM_W-1:0] REG_STATUS    = 4'h6;  // read only

    // interrupt sources
    localparam int INTR_W     = 2;
    localparam int INTR_FRAME = 0;          // start of line 0
    localparam int INTR_LINE  = 1;          // line == line_cmp

    localparam int STATUS_BUSY = 15;        // vram request outstanding

endpackage

`default_nettype wire

/* hdl/vdp_video_pkg.sv */
// vram geometry and scan timing for the video controller
// sizes the counters, the fetch address math and the vram ports
`default_nettype none

package vdp_video_pkg;

    localparam int WORD_W         = 16;     // vram word
    localparam int VADDR_W        = 12;     // vram word address
    localparam int VRAM_WORDS     = 4096;
    localparam int PIX_W          = 4;      // color index per pixel
    localparam int PIX_PER_WORD   = 4;      // msb nibble shown first

    // horizontal, in pixel clocks
    localparam int H_VISIBLE      = 32;
    localparam int H_TOTAL        = 48;
    localparam int HSYNC_START    = 36;
    localparam int HSYNC_END      = 42;     // exclusive

    // vertical, in lines
    localparam int V_VISIBLE      = 8;
    localparam int V_TOTAL        = 12;
    localparam int VSYNC_START    = 9;
    localparam int VSYNC_END      = 10;     // exclusive

    localparam int WORDS_PER_LINE = 8;      // H_VISIBLE / PIX_PER_WORD

    localparam int HCNT_W         = 6;
    localparam int VCNT_W         = 4;

endpackage

`default_nettype wire

/* hdl/video_timing.sv */
// raster counters, sync and enable, vram fetch and pixel shift-out
// pixels leave three clocks after their counter position, syncs are delayed to match
`default_nettype none
`timescale 1ns/100ps

module video_timing(
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic [vdp_video_pkg::VADDR_W-1:0]  disp_base_i,
    input  wire logic [vdp_video_pkg::VCNT_W-1:0]   line_cmp_i,
    output logic                                    vid_rd_o,
    output logic      [vdp_video_pkg::VADDR_W-1:0]  vid_addr_o,
    input  wire logic [vdp_video_pkg::WORD_W-1:0]   vid_rdata_i,
    output logic                                    hsync_o,
    output logic                                    vsync_o,
    output logic                                    dv_de_o,
    output logic      [vdp_video_pkg::PIX_W-1:0]    pixel_o,
    output logic                                    frame_start_o,
    output logic                                    line_match_o
);
    import vdp_video_pkg::*;

    logic [HCNT_W-1:0]  h_cnt;
    logic [VCNT_W-1:0]  v_cnt;
    logic               h_last;
    logic               v_last;
    logic               visible;
    logic               hs;
    logic               vs;
    logic [VADDR_W-1:0] line_off;
    logic [VADDR_W-1:0] col_off;
    logic               load_q;         // vram word arrives this cycle
    logic [WORD_W-1:0]  shift;
    logic [2:0]         ctl_d1;         // {hs, vs, de} delay
    logic [2:0]         ctl_d2;

    assign h_last  = (h_cnt == HCNT_W'(H_TOTAL - 1));
    assign v_last  = (v_cnt == VCNT_W'(V_TOTAL - 1));
    assign visible = (h_cnt < HCNT_W'(H_VISIBLE)) && (v_cnt < VCNT_W'(V_VISIBLE));
    assign hs      = (h_cnt >= HCNT_W'(HSYNC_START)) && (h_cnt < HCNT_W'(HSYNC_END));
    assign vs      = (v_cnt >= VCNT_W'(VSYNC_START)) && (v_cnt < VCNT_W'(VSYNC_END));

    // one fetch per word, on the first pixel of each group of four
    assign line_off   = VADDR_W'(v_cnt) * VADDR_W'(WORDS_PER_LINE);
    assign col_off    = VADDR_W'(h_cnt / HCNT_W'(PIX_PER_WORD));
    assign vid_rd_o   = visible && (h_cnt[1:0] == 2'b00);
    assign vid_addr_o = disp_base_i + line_off + col_off;  // wraps at vram size

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_cnt         <= '0;
            v_cnt         <= '0;
            frame_start_o <= 1'b0;
            line_match_o  <= 1'b0;
        end else begin
            h_cnt <= h_last ? '0 : h_cnt + 1'b1;
            if (h_last) begin
                v_cnt <= v_last ? '0 : v_cnt + 1'b1;
            end
            frame_start_o <= (h_cnt == '0) && (v_cnt == '0);
            line_match_o  <= (h_cnt == '0) && (v_cnt == line_cmp_i);
        end
    end

    // fetch at h, data at h+1, loaded for h+2, on the pins at h+3
    always_ff @(posedge clk) begin
        if (reset_i) begin
            load_q  <= 1'b0;
            shift   <= '0;
            pixel_o <= '0;
            ctl_d1  <= 3'b000;
            ctl_d2  <= 3'b000;
            hsync_o <= 1'b0;
            vsync_o <= 1'b0;
            dv_de_o <= 1'b0;
        end else begin
            load_q  <= vid_rd_o;
            pixel_o <= shift[WORD_W-1 -: PIX_W];    // msb nibble first
            shift   <= load_q ? vid_rdata_i : {shift[WORD_W-PIX_W-1:0], {PIX_W{1'b0}}};
            ctl_d1  <= {hs, vs, visible};
            ctl_d2  <= ctl_d1;
            hsync_o <= ctl_d2[2];
            vsync_o <= ctl_d2[1];
            dv_de_o <= ctl_d2[0];
        end
    end

endmodule

`default_nettype wire

/* hdl/vram_arb.sv */
// single-port video ram shared by scan-out reads and cpu requests
// video reads always win, cpu waits for a free cycle
`default_nettype none
`timescale 1ns/100ps

module vram_arb(
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               vid_rd_i,
    input  wire logic [vdp_video_pkg::VADDR_W-1:0]  vid_addr_i,
    output logic      [vdp_video_pkg::WORD_W-1:0]   vid_rdata_o,    // next cycle
    input  wire logic                               regs_req_i,
    input  wire logic                               regs_wr_i,
    input  wire logic [vdp_video_pkg::VADDR_W-1:0]  regs_addr_i,
    input  wire logic [vdp_video_pkg::WORD_W-1:0]   regs_wdata_i,
    output logic                                    regs_ack_o,
    output logic      [vdp_video_pkg::WORD_W-1:0]   regs_rdata_o    // valid with ack
);
    import vdp_video_pkg::*;

    logic [WORD_W-1:0]  vram [VRAM_WORDS];
    logic [VADDR_W-1:0] mem_addr;
    logic               regs_go;    // cpu owns this cycle

    // cpu only in cycles the scan-out leaves free, once per request
    assign regs_go  = regs_req_i && !regs_ack_o && !vid_rd_i;
    assign mem_addr = vid_rd_i ? vid_addr_i : regs_addr_i;

    always_ff @(posedge clk) begin
        if (regs_go && regs_wr_i) begin
            vram[mem_addr] <= regs_wdata_i;
        end
        if (vid_rd_i) begin
            vid_rdata_o <= vram[mem_addr];
        end else if (regs_go && !regs_wr_i) begin
            regs_rdata_o <= vram[mem_addr];
        end
    end

    // ack rises after the access, falls once req is gone
    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_ack_o <= 1'b0;
        end else if (regs_go) begin
            regs_ack_o <= 1'b1;
        end else if (!regs_req_i) begin
            regs_ack_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* test/vdp_main_tb.sv */
// testbench for vdp_main: random vram and register traffic checked against a model,
// plus scan-out pixel, sync, enable and interrupt checks
`default_nettype none
`timescale 1ns/100ps

module vdp_main_tb;
    import vdp_video_pkg::*;
    import vdp_regs_pkg::*;

    localparam int FRAME = H_TOTAL * V_TOTAL;   // clocks per frame

    logic                   clk;
    logic                   reset_i;
    logic                   bus_cs_n;
    logic                   bus_rd_nwr;
    logic [REG_NUM_W-1:0]   bus_reg_num;
    logic                   bus_bytesel;
    logic [7:0]             bus_wdata;
    logic [7:0]             bus_rdata;
    logic                   bus_intr;
    logic                   hsync;
    logic                   vsync;
    logic                   de;
    logic [PIX_W-1:0]       pixel;

    // model state
    logic [WORD_W-1:0]      m_vram [VRAM_WORDS];
    logic [VADDR_W-1:0]     m_addr;
    logic [VADDR_W-1:0]     m_incr;
    logic [VADDR_W-1:0]     m_base;
    logic [WORD_W-1:0]      m_prefetch;     // what VRAM_DATA reads next
    logic [31:0]            rng;
    int                     value_errs;
    int                     other_errs;

    vdp_main dut(
        .clk(clk),                      .reset_i(reset_i),
        .bus_cs_n_i(bus_cs_n),          .bus_rd_nwr_i(bus_rd_nwr),
        .bus_reg_num_i(bus_reg_num),    .bus_bytesel_i(bus_bytesel),
        .bus_data_i(bus_wdata),         .bus_data_o(bus_rdata),
        .bus_intr_o(bus_intr),          .hsync_o(hsync),
        .vsync_o(vsync),                .dv_de_o(de),
        .pixel_o(pixel)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;                  // 40 ns period

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, got);
        value_errs++;
    endtask

    task automatic report_other(input string what);
        $display("error at t=%0t: %s", $time, what);
        other_errs++;
    endtask

    task automatic end_run();
        $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic give_up(input string what);
        report_other({"timeout, ", what});
        end_run();
    endtask

    // one byte strobe, drive 5 ns after the edge, data_o valid after the next edge
    task automatic bus_cycle(input logic rd, input logic [REG_NUM_W-1:0] num,
                             input logic lo, input logic [7:0] wdata,
                             output logic [7:0] rdata);
        @(posedge clk);
        #5;
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = num;
        bus_bytesel = lo;
        bus_wdata   = wdata;
        @(posedge clk);
        #5;
        bus_cs_n = 1'b1;
        rdata    = bus_rdata;
    endtask

    task automatic bus_write(input logic [REG_NUM_W-1:0] num, input logic lo,
                             input logic [7:0] wdata);
        logic [7:0] unused;
        bus_cycle(1'b0, num, lo, wdata, unused);
    endtask

    task automatic bus_read(input logic [REG_NUM_W-1:0] num, input logic lo,
                            output logic [7:0] rdata);
        bus_cycle(1'b1, num, lo, 8'h00, rdata);
    endtask

    task automatic write_word(input logic [REG_NUM_W-1:0] num, input logic [WORD_W-1:0] w);
        bus_write(num, 1'b0, w[15:8]);          // held until the low byte
        bus_write(num, 1'b1, w[7:0]);
    endtask

    task automatic read_word(input logic [REG_NUM_W-1:0] num, output logic [WORD_W-1:0] w);
        logic [7:0] hi;
        logic [7:0] lo;
        bus_read(num, 1'b0, hi);
        bus_read(num, 1'b1, lo);                // low read last, it may refill
        w = {hi, lo};
    endtask

    task automatic check_reg(input logic [REG_NUM_W-1:0] num, input logic [WORD_W-1:0] exp);
        logic [WORD_W-1:0] got;
        read_word(num, got);
        if (got !== exp) report_value($sformatf("bus_data_o (reg %0d)", num), 32'(exp),
                                      32'(got));
    endtask

    // poll busy until the vram request has finished
    task automatic wait_idle();
        logic [7:0] st;
        int n;
        n = 0;
        bus_read(REG_STATUS, 1'b0, st);
        while (st[STATUS_BUSY-8] && n < 16) begin
            bus_read(REG_STATUS, 1'b0, st);
            n++;
        end
        if (st[STATUS_BUSY-8]) give_up("STATUS busy never cleared");
    endtask

    task automatic set_vram_addr(input logic [VADDR_W-1:0] a);
        write_word(REG_VRAM_ADDR, WORD_W'(a));
        wait_idle();
        m_prefetch = m_vram[a];                 // commit prefetches at a
        m_addr     = a + m_incr;
    endtask

    task automatic vram_put(input logic [WORD_W-1:0] w);
        write_word(REG_VRAM_DATA, w);
        wait_idle();
        m_vram[m_addr] = w;
        m_addr         = m_addr + m_incr;       // wraps at 4096
    endtask

    task automatic check_vram_read();
        logic [WORD_W-1:0] got;
        read_word(REG_VRAM_DATA, got);
        wait_idle();
        if (got !== m_prefetch) report_value("bus_data_o (VRAM_DATA)", 32'(m_prefetch),
                                             32'(got));
        m_prefetch = m_vram[m_addr];
        m_addr     = m_addr + m_incr;
    endtask

    task automatic wait_vsync(input logic level);
        int n;
        n = 0;
        while (vsync !== level && n < 2 * FRAME) begin
            @(negedge clk);
            n++;
        end
        if (vsync !== level) give_up("vsync_o stuck");
    endtask

    task automatic wait_de_high();
        int n;
        n = 0;
        while (de !== 1'b1 && n < 2 * FRAME) begin
            @(negedge clk);
            n++;
        end
        if (de !== 1'b1) give_up("dv_de_o never went high");
    endtask

    task automatic wait_intr_high(input int limit);
        int n;
        n = 0;
        while (bus_intr !== 1'b1 && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (bus_intr !== 1'b1) give_up("bus_intr_o did not rise");
    endtask

    // one whole frame of pixels and syncs, from the end of vsync to the next vsync
    task automatic check_frame();
        int n;
        int run;
        int lines;
        int cyc;
        int x;
        int y;
        int vs_len;
        int hs_len;
        int pulses;
        int gap;                                // clocks since enable fell, -1 when none
        logic [VADDR_W-1:0] a;
        logic [WORD_W-1:0]  w;
        logic [PIX_W-1:0]   exp_pix;
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        vs_len = 0;
        while (vsync === 1'b1 && vs_len < 2 * FRAME) begin
            @(negedge clk);
            vs_len++;
        end
        if (vsync !== 1'b0) give_up("vsync_o stuck high");
        if (vs_len != (VSYNC_END - VSYNC_START) * H_TOTAL) begin
            report_other($sformatf("vsync_o high for %0d clocks", vs_len));
        end
        n      = 0;
        run    = 0;
        lines  = 0;
        cyc    = 0;
        hs_len = 0;
        pulses = 0;
        gap    = -1;
        while (vsync === 1'b0 && cyc < 2 * FRAME) begin
            @(negedge clk);
            cyc++;
            if (gap >= 0) gap++;
            if (hsync === 1'b1) begin
                // front porch between the last pixel and hsync
                if (gap >= 0 && gap != HSYNC_START - H_VISIBLE) begin
                    report_other($sformatf("hsync_o %0d clocks after dv_de_o fell", gap));
                end
                gap = -1;
                hs_len++;
            end else if (hs_len != 0) begin
                if (hs_len != HSYNC_END - HSYNC_START) begin
                    report_other($sformatf("hsync_o high for %0d clocks", hs_len));
                end
                hs_len = 0;
                pulses++;
            end
            if (de === 1'b1) begin
                y       = n / H_VISIBLE;
                x       = n % H_VISIBLE;
                a       = m_base + VADDR_W'(y * WORDS_PER_LINE + x / PIX_PER_WORD);
                w       = m_vram[a];
                exp_pix = w[(PIX_PER_WORD - 1 - x % PIX_PER_WORD) * PIX_W +: PIX_W];
                if (pixel !== exp_pix) report_value("pixel_o", 32'(exp_pix), 32'(pixel));
                n++;
                run++;
            end else if (run != 0) begin
                if (run != H_VISIBLE) report_other($sformatf("line of %0d pixels", run));
                run   = 0;
                gap   = 0;
                lines++;
            end
        end
        if (vsync !== 1'b1) begin
            give_up("no vsync_o after the visible lines");
        end else begin
            if (lines != V_VISIBLE) report_other($sformatf("frame of %0d lines", lines));
            if (pulses != V_TOTAL - (VSYNC_END - VSYNC_START)) begin
                report_other($sformatf("%0d hsync_o pulses between vsyncs", pulses));
            end
        end
    endtask

    // vram traffic while lines are shown, kept clear of the displayed words
    task automatic cpu_during_scan();
        logic [VADDR_W-1:0] a;
        a = m_base + VADDR_W'(12'h100);
        wait_vsync(1'b0);
        wait_vsync(1'b1);
        wait_vsync(1'b0);
        wait_de_high();
        set_vram_addr(a);
        for (int i = 0; i < 6; i++) begin
            vram_put(WORD_W'(next_random()));
        end
        set_vram_addr(a);
        for (int i = 0; i < 7; i++) begin
            check_vram_read();
        end
    endtask

    initial begin
        logic [31:0]        r;
        logic [VADDR_W-1:0] start;
        logic [VADDR_W-1:0] incr;
        logic [VCNT_W-1:0]  lcmp;
        logic [INTR_W-1:0]  mask;
        logic [7:0]         st;
        int                 n;
        rng         = 32'hc120;
        value_errs  = 0;
        other_errs  = 0;
        reset_i     = 1'b1;
        bus_cs_n    = 1'b1;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = '0;
        bus_bytesel = 1'b0;
        bus_wdata   = 8'h00;
        m_addr      = '0;
        m_incr      = VADDR_W'(1);
        m_base      = '0;
        m_prefetch  = '0;
        repeat (10) @(posedge clk);
        #5;
        reset_i = 1'b0;

        check_reg(REG_VRAM_INCR, 16'h0001);     // reset value
        set_vram_addr(12'hfff);                 // next write lands at 0
        for (int i = 0; i < VRAM_WORDS; i++) begin
            vram_put(WORD_W'(next_random()));
        end

        // random start and stride, large strides wrap
        r     = next_random();
        start = VADDR_W'(r);
        r     = next_random();
        incr  = VADDR_W'(r % 32'd4095) + 12'd1;
        write_word(REG_VRAM_INCR, WORD_W'(incr));
        m_incr = incr;
        set_vram_addr(start);
        for (int i = 0; i < 24; i++) begin
            vram_put(WORD_W'(next_random()));
        end
        set_vram_addr(start);
        for (int i = 0; i < 25; i++) begin
            check_vram_read();
        end

        // register read-back
        check_reg(REG_VRAM_ADDR, WORD_W'(m_addr));
        r      = next_random();
        m_incr = VADDR_W'(r);
        write_word(REG_VRAM_INCR, WORD_W'(m_incr));
        check_reg(REG_VRAM_INCR, WORD_W'(m_incr));
        r    = next_random();
        lcmp = VCNT_W'(r % 32'(V_TOTAL - 1)) + VCNT_W'(1);  // nonzero line that occurs
        write_word(REG_LINE_CMP, WORD_W'(lcmp));
        check_reg(REG_LINE_CMP, WORD_W'(lcmp));
        r      = next_random();
        m_base = VADDR_W'(r);
        write_word(REG_DISP_BASE, WORD_W'(m_base));
        check_reg(REG_DISP_BASE, WORD_W'(m_base));
        r    = next_random();
        mask = INTR_W'(r % 32'd3) + INTR_W'(1); // never the reset value
        bus_write(REG_INTR, 1'b0, 8'(mask));
        bus_read(REG_INTR, 1'b0, st);
        if (st !== 8'(mask)) report_value("bus_data_o (INTR mask)", 32'(mask), 32'(st));
        bus_write(REG_INTR, 1'b0, 8'h00);
        for (int i = 7; i < 16; i++) begin
            check_reg(REG_NUM_W'(i), 16'h0000); // unused
        end

        check_frame();

        // frame interrupt
        bus_write(REG_INTR, 1'b1, 8'h03);
        bus_write(REG_INTR, 1'b0, 8'(1 << INTR_FRAME));
        wait_intr_high(FRAME + 8);
        bus_read(REG_INTR, 1'b1, st);
        if (st[INTR_FRAME] !== 1'b1) report_value("bus_data_o (INTR frame)", 1,
                                                  32'(st[INTR_FRAME]));
        bus_write(REG_INTR, 1'b1, 8'h03);
        bus_read(REG_INTR, 1'b1, st);           // well before line 1 starts
        if (st !== 8'h00) report_value("bus_data_o (INTR status)", 0, 32'(st));
        bus_write(REG_INTR, 1'b0, 8'h00);

        // line interrupt held off by the mask
        bus_write(REG_INTR, 1'b1, 8'h03);
        n = 0;
        for (int i = 0; i < FRAME + 8; i++) begin
            @(negedge clk);
            if (bus_intr !== 1'b0) n++;
        end
        if (n != 0) report_value("bus_intr_o", 0, 1);
        bus_read(REG_INTR, 1'b1, st);
        if (st[INTR_LINE] !== 1'b1) report_value("bus_data_o (INTR line)", 1,
                                                 32'(st[INTR_LINE]));
        bus_write(REG_INTR, 1'b0, 8'(1 << INTR_LINE));
        wait_intr_high(8);
        bus_write(REG_INTR, 1'b0, 8'h00);
        bus_write(REG_INTR, 1'b1, 8'h03);

        // cpu traffic against scan-out
        write_word(REG_VRAM_INCR, 16'h0001);
        m_incr = VADDR_W'(1);
        fork
            check_frame();
            cpu_during_scan();
        join
        end_run();
    end

endmodule

`default_nettype wire

/* vdp.f */
hdl/vdp_video_pkg.sv
hdl/vdp_regs_pkg.sv
hdl/bus_regs.sv
hdl/vram_arb.sv
hdl/video_timing.sv
hdl/intr_ctrl.sv
hdl/vdp_main.sv
test/vdp_main_tb.sv
